// File: cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;   // rv32e has sixteen registers.
    typedef logic [2:0]  alu_op_t;
    typedef logic [6:0]  opcode_t;

    localparam word_t RESET_PC = 32'h8000_0000;
    localparam int    REG_NUM  = 16;

    localparam alu_op_t ALU_ADD   = 3'd0;
    localparam alu_op_t ALU_SUB   = 3'd1;
    localparam alu_op_t ALU_AND   = 3'd2;
    localparam alu_op_t ALU_OR    = 3'd3;
    localparam alu_op_t ALU_XOR   = 3'd4;
    localparam alu_op_t ALU_SLT   = 3'd5;
    localparam alu_op_t ALU_PASSB = 3'd6;

    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;

    typedef struct packed {
        logic    reg_wen;
        logic    mem_rd;
        logic    mem_wr;
        logic    use_imm;
        logic    use_pc;
        logic    is_branch;
        logic    is_jal;
        logic    is_jalr;
        logic    br_ne;
        alu_op_t alu_op;
    } dec_t;

    typedef struct packed {
        logic  start;
        logic  wr;
        word_t addr;
        word_t wdata;
    } bus_req_t;

    typedef enum logic [1:0] {IF_IDLE, IF_WAIT, IF_HOLD} ifu_state_t;
    typedef enum logic [2:0] {LS_IDLE, LS_AR, LS_R, LS_AW, LS_B} lsu_state_t;

endpackage

// File: cpu_ifu.sv
`timescale 1ns/10ps

module cpu_ifu import cpu_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  next_ok,
    input  logic  fill,
    input  word_t fill_data,
    output logic  if_phase,
    output logic  if_start,
    output word_t inst,
    output logic  inst_ok
);

    ifu_state_t state;

    assign if_start = (state == IF_IDLE);   // one cycle, the fsm never waits here.
    assign if_phase = (state != IF_HOLD);   // bus belongs to fetch until the word arrives.

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state   <= IF_IDLE;
            inst    <= '0;
            inst_ok <= 1'b0;
        end else begin
            inst_ok <= 1'b0;
            case (state)
                IF_IDLE: begin
                    state <= IF_WAIT;
                end
                IF_WAIT: begin
                    if (fill) begin
                        inst    <= fill_data;
                        inst_ok <= 1'b1;
                        state   <= IF_HOLD;
                    end
                end
                IF_HOLD: begin
                    if (next_ok) begin
                        state <= IF_IDLE;   // pc is already updated here.
                    end
                end
                default: state <= IF_IDLE;
            endcase
        end
    end

endmodule

// File: cpu_idu.sv
`timescale 1ns/10ps

module cpu_idu import cpu_pkg::*; (
    input  word_t     inst,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output word_t     imm,
    output dec_t      dec
);

    opcode_t    opcode;
    logic [2:0] funct3;
    alu_op_t    f3_op;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rs1    = inst[18:15];   // upper index bit is dropped for rv32e.
    assign rs2    = inst[23:20];
    assign rd     = inst[10:7];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (funct3)
            3'b010:  f3_op = ALU_SLT;
            3'b100:  f3_op = ALU_XOR;
            3'b110:  f3_op = ALU_OR;
            3'b111:  f3_op = ALU_AND;
            default: f3_op = ALU_ADD;
        endcase
    end

    always_comb begin
        dec        = '0;   // unknown opcodes just fall through to pc+4.
        dec.alu_op = ALU_ADD;
        imm        = '0;
        case (opcode)
            OP_LUI: begin
                imm         = imm_u;
                dec.reg_wen = 1'b1;
                dec.use_imm = 1'b1;
                dec.alu_op  = ALU_PASSB;
            end
            OP_AUIPC: begin
                imm         = imm_u;
                dec.reg_wen = 1'b1;
                dec.use_imm = 1'b1;
                dec.use_pc  = 1'b1;
            end
            OP_IMM: begin
                imm         = imm_i;
                dec.reg_wen = 1'b1;
                dec.use_imm = 1'b1;
                dec.alu_op  = f3_op;
            end
            OP_REG: begin
                dec.reg_wen = 1'b1;
                dec.alu_op  = (funct3 == 3'b000 && inst[30]) ? ALU_SUB : f3_op;
            end
            OP_LOAD: begin
                imm         = imm_i;
                dec.reg_wen = 1'b1;
                dec.mem_rd  = 1'b1;
                dec.use_imm = 1'b1;
            end
            OP_STORE: begin
                imm         = imm_s;
                dec.mem_wr  = 1'b1;
                dec.use_imm = 1'b1;
            end
            OP_BRANCH: begin
                imm           = imm_b;
                dec.is_branch = 1'b1;
                dec.br_ne     = funct3[0];   // bne is funct3 001.
            end
            OP_JAL: begin
                imm         = imm_j;
                dec.reg_wen = 1'b1;
                dec.is_jal  = 1'b1;
            end
            OP_JALR: begin
                imm         = imm_i;
                dec.reg_wen = 1'b1;
                dec.is_jalr = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: cpu_regfile.sv
`timescale 1ns/10ps

module cpu_regfile import cpu_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      wen,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [REG_NUM];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: cpu_exu.sv
`timescale 1ns/10ps

module cpu_exu import cpu_pkg::*; (
    input  dec_t  dec,
    input  word_t rs1_d,
    input  word_t rs2_d,
    input  word_t imm,
    input  word_t pc,
    output word_t result,
    output logic  taken
);

    word_t op_a;
    word_t op_b;

    assign op_a = dec.use_pc ? pc : rs1_d;
    assign op_b = dec.use_imm ? imm : rs2_d;

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:   result = op_a - op_b;
            ALU_AND:   result = op_a & op_b;
            ALU_OR:    result = op_a | op_b;
            ALU_XOR:   result = op_a ^ op_b;
            ALU_SLT:   result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASSB: result = op_b;   // lui.
            default:   result = op_a + op_b;
        endcase
    end

    // branch compare always uses the register operands.
    assign taken = dec.is_jal || dec.is_jalr ||
                   (dec.is_branch && ((rs1_d == rs2_d) != dec.br_ne));

endmodule

// File: cpu_lsu.sv
`timescale 1ns/10ps

module cpu_lsu import cpu_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  bus_req_t req,
    output logic     done,
    output word_t    rsp_data,

    input  logic     awready,
    output logic     awvalid,
    output word_t    awaddr,
    input  logic     wready,
    output logic     wvalid,
    output word_t    wdata,
    output logic     bready,
    input  logic     bvalid,
    input  logic     arready,
    output logic     arvalid,
    output word_t    araddr,
    output logic     rready,
    input  logic     rvalid,
    input  word_t    rdata
);

    lsu_state_t state;
    word_t      addr_q;
    logic       aw_fin;
    logic       w_fin;

    assign awaddr = addr_q;
    assign araddr = addr_q;
    assign aw_fin = !awvalid || awready;   // address already taken or taken now.
    assign w_fin  = !wvalid || wready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state   <= LS_IDLE;
            done    <= 1'b0;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                LS_IDLE: begin
                    if (req.start && req.wr) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= LS_AW;
                    end else if (req.start) begin
                        arvalid <= 1'b1;
                        state   <= LS_AR;
                    end
                end
                LS_AR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= LS_R;
                    end
                end
                LS_R: begin
                    if (rvalid) begin
                        rready <= 1'b0;
                        done   <= 1'b1;
                        state  <= LS_IDLE;
                    end
                end
                LS_AW: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if (aw_fin && w_fin) begin
                        bready <= 1'b1;
                        state  <= LS_B;
                    end
                end
                LS_B: begin
                    if (bvalid) begin
                        bready <= 1'b0;
                        done   <= 1'b1;
                        state  <= LS_IDLE;
                    end
                end
                default: state <= LS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == LS_IDLE && req.start) begin
            addr_q <= req.addr;
            wdata  <= req.wdata;
        end
        if (state == LS_R && rvalid) begin
            rsp_data <= rdata;   // valid together with done.
        end
    end

endmodule

// File: cpu_pcu.sv
`timescale 1ns/10ps

module cpu_pcu import cpu_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  ready,
    input  logic  taken,
    input  dec_t  dec,
    input  word_t imm,
    input  word_t rs1_d,
    output word_t pc,
    output logic  next_ok
);

    word_t jalr_tgt;
    word_t pc_next;

    assign jalr_tgt = rs1_d + imm;

    always_comb begin
        if (dec.is_jalr) begin
            pc_next = {jalr_tgt[31:1], 1'b0};
        end else if (taken) begin
            pc_next = pc + imm;   // taken branch or jal.
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc      <= RESET_PC;
            next_ok <= 1'b0;
        end else begin
            next_ok <= ready;
            if (ready) begin
                pc <= pc_next;
            end
        end
    end

endmodule

// File: cpu_top.sv
`timescale 1ns/10ps

module cpu_top import cpu_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,
    output word_t pc,
    output word_t inst,
    output logic  retire,

    input  logic  awready,
    output logic  awvalid,
    output word_t awaddr,
    input  logic  wready,
    output logic  wvalid,
    output word_t wdata,
    output logic  bready,
    input  logic  bvalid,
    input  logic  arready,
    output logic  arvalid,
    output word_t araddr,
    output logic  rready,
    input  logic  rvalid,
    input  word_t rdata
);

    logic      if_phase;
    logic      if_start;
    logic      inst_ok;
    logic      args_ok;
    logic      next_ok;
    logic      fill;
    logic      mem_acc;
    logic      taken;
    logic      lsu_done;
    word_t     lsu_rdata;
    bus_req_t  lsu_req;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    word_t     rs1_d;
    word_t     rs2_d;
    word_t     result;
    word_t     wb_data;
    word_t     pc_plus4;
    dec_t      dec;

    assign mem_acc  = dec.mem_rd | dec.mem_wr;
    assign fill     = if_phase & lsu_done;
    assign args_ok  = mem_acc ? (~if_phase & lsu_done) : inst_ok;
    assign retire   = next_ok;
    assign pc_plus4 = pc + 32'd4;

    // simple arbiter, fetch owns the bus while if_phase is high.
    always_comb begin
        lsu_req.wdata = rs2_d;
        if (if_phase) begin
            lsu_req.start = if_start;
            lsu_req.wr    = 1'b0;
            lsu_req.addr  = pc;
        end else begin
            lsu_req.start = inst_ok & mem_acc;
            lsu_req.wr    = dec.mem_wr;
            lsu_req.addr  = result;   // rs1 + imm.
        end
    end

    always_comb begin
        if (dec.mem_rd) begin
            wb_data = lsu_rdata;
        end else if (dec.is_jal || dec.is_jalr) begin
            wb_data = pc_plus4;   // link value.
        end else begin
            wb_data = result;
        end
    end

    cpu_ifu u_ifu (
        .clock     (clock),
        .rst_n     (rst_n),
        .next_ok   (next_ok),
        .fill      (fill),
        .fill_data (lsu_rdata),
        .if_phase  (if_phase),
        .if_start  (if_start),
        .inst      (inst),
        .inst_ok   (inst_ok)
    );

    cpu_idu u_idu (
        .inst (inst),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .imm  (imm),
        .dec  (dec)
    );

    cpu_regfile u_reg (
        .clock  (clock),
        .rst_n  (rst_n),
        .wen    (dec.reg_wen & args_ok),
        .waddr  (rd),
        .wdata  (wb_data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_d),
        .rdata2 (rs2_d)
    );

    cpu_exu u_exu (
        .dec    (dec),
        .rs1_d  (rs1_d),
        .rs2_d  (rs2_d),
        .imm    (imm),
        .pc     (pc),
        .result (result),
        .taken  (taken)
    );

    cpu_lsu u_lsu (
        .clock    (clock),
        .rst_n    (rst_n),
        .req      (lsu_req),
        .done     (lsu_done),
        .rsp_data (lsu_rdata),
        .awready  (awready),
        .awvalid  (awvalid),
        .awaddr   (awaddr),
        .wready   (wready),
        .wvalid   (wvalid),
        .wdata    (wdata),
        .bready   (bready),
        .bvalid   (bvalid),
        .arready  (arready),
        .arvalid  (arvalid),
        .araddr   (araddr),
        .rready   (rready),
        .rvalid   (rvalid),
        .rdata    (rdata)
    );

    cpu_pcu u_pcu (
        .clock   (clock),
        .rst_n   (rst_n),
        .ready   (args_ok),
        .taken   (taken),
        .dec     (dec),
        .imm     (imm),
        .rs1_d   (rs1_d),
        .pc      (pc),
        .next_ok (next_ok)
    );

endmodule

// File: tb_sva.sv
`timescale 1ns/10ps

module cpu_sva_checks (
    input logic        clock,
    input logic        rst_n,
    input logic        arvalid,
    input logic        arready,
    input logic [31:0] araddr,
    input logic        awvalid,
    input logic        awready,
    input logic        wvalid,
    input logic        wready,
    input logic        rready,
    input logic        bready
);

    ar_hold: assert property (@(posedge clock) disable iff (!rst_n)
        arvalid && !arready |=> arvalid) else $error("arvalid dropped before arready");
    aw_hold: assert property (@(posedge clock) disable iff (!rst_n)
        awvalid && !awready |=> awvalid) else $error("awvalid dropped before awready");
    w_hold: assert property (@(posedge clock) disable iff (!rst_n)
        wvalid && !wready |=> wvalid) else $error("wvalid dropped before wready");
    ar_stable: assert property (@(posedge clock) disable iff (!rst_n)
        arvalid && !arready |=> $stable(araddr)) else $error("araddr changed while waiting");
    one_rd: assert property (@(posedge clock) disable iff (!rst_n)
        (arvalid || rready) |-> !(awvalid || wvalid || bready))
        else $error("read and write outstanding together");

endmodule

// File: tb_checker.sv
`timescale 1ns/10ps

module tb_checker import cpu_pkg::*; #(
    parameter int WORDS = 256
) (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  retire,
    input  word_t pc,
    input  word_t inst,
    input  logic  arvalid,
    input  word_t araddr,
    input  logic  awvalid,
    input  logic  awready,
    input  word_t awaddr,
    input  logic  wvalid,
    input  logic  wready,
    input  word_t wdata,
    input  logic  bvalid,
    input  logic  bready,
    input  word_t image [WORDS],
    output logic  halted,
    output int    n_checks,
    output int    n_errors
);

    word_t       sreg [16];
    word_t       smem [WORDS];
    word_t       spc;
    logic        st_valid;
    word_t       st_addr;
    word_t       st_data;
    word_t       aw_seen;
    word_t       w_seen;
    logic [63:0] wr_obs [$];
    logic        fetch_seen;
    int          retired;
    int          stores;
    int          sect_err;

    function automatic word_t alu_ref(input logic [2:0] f3, input logic sub,
                                      input word_t a, input word_t b);
        case (f3)
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return sub ? a - b : a + b;
        endcase
    endfunction

    // executes one word on the shadow state.
    function automatic void ref_step(input word_t w);
        logic [2:0] f3;
        reg_addr_t  rd;
        word_t      a;
        word_t      b;
        word_t      ii;
        word_t      nxt;
        word_t      val;
        logic       wb;
        f3  = w[14:12];
        rd  = w[10:7];
        a   = sreg[w[18:15]];
        b   = sreg[w[23:20]];
        ii  = {{20{w[31]}}, w[31:20]};
        nxt = spc + 4;
        wb  = 1'b1;
        val = '0;
        st_valid = 1'b0;
        case (w[6:0])
            OP_LUI:   val = {w[31:12], 12'b0};
            OP_AUIPC: val = spc + {w[31:12], 12'b0};
            OP_IMM:   val = alu_ref(f3, 1'b0, a, ii);
            OP_REG:   val = alu_ref(f3, w[30], a, b);
            OP_LOAD:  val = smem[(a + ii) >> 2 & (WORDS - 1)];
            OP_STORE: begin
                wb       = 1'b0;
                st_valid = 1'b1;
                st_addr  = a + {{20{w[31]}}, w[31:25], w[11:7]};
                st_data  = b;
                smem[st_addr >> 2 & (WORDS - 1)] = b;
            end
            OP_BRANCH: begin
                wb = 1'b0;
                if ((a == b) != f3[0]) begin
                    nxt = spc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            OP_JAL: begin
                val = spc + 4;
                nxt = spc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            OP_JALR: begin
                val = spc + 4;
                nxt = (a + ii) & ~32'd1;   // target uses rs1 before the link write.
            end
            default: wb = 1'b0;
        endcase
        if (wb && rd != 0) begin
            sreg[rd] = val;
        end
        spc = nxt;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            sect_err++;
            $display("** Error @ %0t: %s expected %08h actual %08h", $time, name, exp, act);
        end
    endtask

    task automatic fail_plain(input string what);
        n_errors++;
        sect_err++;
        $display("error @ %0t: %s", $time, what);
    endtask

    task automatic end_section(input string name);
        $display("test %s done, %0d errors", name, sect_err);
        sect_err = 0;
    endtask

    always @(posedge clock) begin
        word_t       exp_inst;
        word_t       old_pc;
        logic [63:0] obs;
        if (!rst_n) begin
            for (int i = 0; i < WORDS; i++) begin
                smem[i] = image[i];
            end
            for (int i = 0; i < 16; i++) begin
                sreg[i] = '0;
            end
            spc        = RESET_PC;
            halted     = 1'b0;
            fetch_seen = 1'b0;
            retired    = 0;
            stores     = 0;
            sect_err   = 0;
            n_checks   = 0;
            n_errors   = 0;
            wr_obs.delete();
        end else begin
            if (arvalid && !fetch_seen) begin
                fetch_seen = 1'b1;
                check_word("araddr", RESET_PC, araddr);
            end
            if (retire && !fetch_seen) begin
                fail_plain("retire came before the first fetch");
            end
            if (awvalid && awready) aw_seen = awaddr;
            if (wvalid && wready) w_seen = wdata;
            if (bvalid && bready) wr_obs.push_back({aw_seen, w_seen});
            if (retire && !halted) begin
                exp_inst = smem[spc >> 2 & (WORDS - 1)];
                old_pc   = spc;
                check_word("inst", exp_inst, inst);
                ref_step(exp_inst);
                check_word("pc", spc, pc);
                retired++;
                if (retired == 1) end_section("reset and first fetch");
                if (st_valid) begin
                    stores++;
                    if (wr_obs.size() == 0) begin
                        fail_plain("a store retired without an AXI write");
                    end else begin
                        obs = wr_obs.pop_front();
                        check_word("awaddr", st_addr, obs[63:32]);
                        check_word("wdata", st_data, obs[31:0]);
                    end
                end
                // addi x0, x0, k closes section k.
                if (exp_inst[19:0] == 20'h00013 && exp_inst[31:20] inside {[2:4]}) begin
                    case (exp_inst[31:20])
                        12'd2:   end_section("arithmetic");
                        12'd3:   end_section("load and store");
                        default: end_section("control flow");
                    endcase
                end
                if (spc == old_pc) begin
                    halted = 1'b1;
                    if (wr_obs.size() != 0) fail_plain("AXI write seen with no store");
                    $display("back-pressure run: %0d retired, %0d stores", retired, stores);
                    sect_err = n_errors;   // every section ran under back-pressure.
                    end_section("back-pressure");
                end
            end
        end
    end

endmodule

// File: tb_top.sv
`timescale 1ns/10ps

module tb_top import cpu_pkg::*; ();

    localparam int WORDS   = 256;
    localparam int CPI_MAX = 30;   // fetch and data access at the worst 3-cycle delays.

    logic        clock;
    logic        rst_n;
    word_t       pc;
    word_t       inst;
    logic        retire;
    logic        awready, awvalid, wready, wvalid, bready, bvalid;
    logic        arready, arvalid, rready, rvalid;
    word_t       awaddr, wdata, araddr, rdata;
    word_t       mem [WORDS];
    logic [15:0] lfsr_q;
    int          n_words;
    logic        halted;
    int          n_checks;
    int          n_errors;
    logic        ar_hs, r_hs, aw_hs, w_hs, b_hs;
    word_t       rd_addr, wr_addr, wr_data;
    logic        rd_pend, aw_got, w_got;
    logic [1:0]  ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;

    cpu_top dut (.*);

    tb_checker #(.WORDS(WORDS)) u_chk (
        .clock(clock), .rst_n(rst_n), .retire(retire), .pc(pc), .inst(inst),
        .arvalid(arvalid), .araddr(araddr), .awvalid(awvalid), .awready(awready),
        .awaddr(awaddr), .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready), .image(mem), .halted(halted),
        .n_checks(n_checks), .n_errors(n_errors)
    );

    bind cpu_lsu cpu_sva_checks u_sva (
        .clock(clock), .rst_n(rst_n), .arvalid(arvalid), .arready(arready),
        .araddr(araddr), .awvalid(awvalid), .awready(awready), .wvalid(wvalid),
        .wready(wready), .rready(rready), .bready(bready)
    );

    // galois lfsr, one step per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 16'hB400 : lfsr_q >> 1;
        end
        return v;
    endfunction

    function automatic word_t enc_i(input opcode_t op, input reg_addr_t rd,
                                    input logic [2:0] f3, input reg_addr_t rs1,
                                    input logic [11:0] imm);
        return {imm, 1'b0, rs1, f3, 1'b0, rd, op};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, OP_REG};
    endfunction

    function automatic word_t enc_s(input reg_addr_t rs2, input reg_addr_t rs1,
                                    input logic [11:0] off);
        return {off[11:5], 1'b0, rs2, 1'b0, rs1, 3'b010, off[4:0], OP_STORE};
    endfunction

    function automatic word_t enc_b(input logic [2:0] f3, input reg_addr_t rs1,
                                    input reg_addr_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], 1'b0, rs2, 1'b0, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t enc_u(input opcode_t op, input reg_addr_t rd,
                                    input logic [19:0] imm);
        return {imm, 1'b0, rd, op};
    endfunction

    function automatic word_t enc_j(input reg_addr_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 1'b0, rd, OP_JAL};
    endfunction

    task automatic emit(input word_t w);
        mem[n_words] = w;
        n_words++;
    endtask

    task automatic build_image();
        word_t       a;
        logic [11:0] o1;
        logic [11:0] o2;
        for (int i = 0; i < WORDS; i++) begin
            a      = RESET_PC + 4 * i;
            mem[i] = a ^ {a[12:0], a[31:13]} ^ 32'h5A5A_0F0F;
        end
        n_words = 0;
        emit(enc_u(OP_LUI, 1, 20'h80000));
        emit(enc_i(OP_IMM, 1, 3'b000, 1, 12'h200));   // x1 points at the data area.
        emit(enc_i(OP_IMM, 2, 3'b000, 0, 12'(rand_bits(12))));
        emit(enc_i(OP_IMM, 3, 3'b000, 0, 12'(rand_bits(12))));
        emit(enc_r(7'h00, 3, 2, 3'b000, 4));
        emit(enc_r(7'h20, 3, 2, 3'b000, 5));
        emit(enc_r(7'h00, 3, 2, 3'b111, 6));
        emit(enc_r(7'h00, 3, 2, 3'b110, 7));
        emit(enc_r(7'h00, 3, 2, 3'b100, 8));
        emit(enc_r(7'h00, 3, 2, 3'b010, 9));
        emit(enc_u(OP_AUIPC, 10, 20'(rand_bits(20))));
        emit(enc_i(OP_IMM, 0, 3'b000, 2, 12'(rand_bits(12))));
        emit(enc_u(OP_LUI, 11, 20'(rand_bits(20))));
        emit(enc_i(OP_IMM, 12, 3'b100, 2, 12'(rand_bits(12))));
        emit(enc_i(OP_IMM, 13, 3'b010, 2, 12'(rand_bits(12))));
        emit(enc_i(OP_IMM, 14, 3'b110, 3, 12'(rand_bits(12))));
        emit(enc_i(OP_IMM, 15, 3'b111, 3, 12'(rand_bits(12))));
        for (int r = 0; r < 16; r++) begin
            emit(enc_s(r[3:0], 1, 12'(4 * r)));
        end
        emit(enc_i(OP_IMM, 0, 3'b000, 0, 12'd2));
        for (int k = 0; k < 4; k++) begin
            o1 = {3'b000, 7'(rand_bits(7)), 2'b00};
            o2 = {3'b000, 7'(rand_bits(7)), 2'b00};
            emit(enc_i(OP_LOAD, 2, 3'b010, 1, o1));
            emit(enc_s(2, 1, o2));
            emit(enc_i(OP_LOAD, 3, 3'b010, 1, o2));
            emit(enc_r(7'h00, 2, 3, 3'b000, 4));
            emit(enc_s(4, 1, o1));
        end
        emit(enc_i(OP_IMM, 0, 3'b000, 0, 12'd3));
        emit(enc_b(3'b000, 0, 0, 13'd8));
        emit(enc_i(OP_IMM, 15, 3'b000, 0, 12'h7ff));   // skipped.
        emit(enc_b(3'b001, 2, 2, 13'd8));
        emit(enc_i(OP_IMM, 15, 3'b000, 15, 12'd1));
        emit(enc_b(3'b001, 2, 3, 13'd8));
        emit(enc_i(OP_IMM, 15, 3'b000, 15, 12'd2));
        emit(enc_b(3'b000, 2, 3, 13'd8));
        emit(enc_i(OP_IMM, 15, 3'b000, 15, 12'd4));
        emit(enc_j(14, 21'd8));
        emit(enc_i(OP_IMM, 15, 3'b000, 15, 12'd8));    // skipped.
        emit(enc_u(OP_AUIPC, 5, 20'h0));
        emit(enc_i(OP_JALR, 6, 3'b000, 5, 12'd13));    // odd target, bit 0 cleared.
        emit(enc_i(OP_IMM, 15, 3'b000, 15, 12'd16));
        emit(enc_s(14, 1, 12'h1f0));
        emit(enc_s(6, 1, 12'h1f4));
        emit(enc_s(15, 1, 12'h1f8));
        emit(enc_i(OP_IMM, 0, 3'b000, 0, 12'd4));
        emit(enc_j(0, 21'd0));
    endtask

    always @(posedge clock) begin
        ar_hs <= arvalid && arready;
        r_hs  <= rvalid && rready;
        aw_hs <= awvalid && awready;
        w_hs  <= wvalid && wready;
        b_hs  <= bvalid && bready;
        if (arvalid && arready) rd_addr <= araddr;
        if (awvalid && awready) wr_addr <= awaddr;
        if (wvalid && wready) wr_data <= wdata;
        if (bvalid && bready) mem[wr_addr[9:2]] <= wr_data;
    end

    // memory model, each channel waits 0 to 3 cycles per beat.
    always @(negedge clock) begin
        if (!rst_n) begin
            {arready, rvalid, awready, wready, bvalid} = '0;
            {rd_pend, aw_got, w_got} = '0;
            {ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt} = '0;
        end else begin
            if (ar_hs) begin
                rd_pend = 1'b1;
                ar_cnt  = 2'(rand_bits(2));
            end
            if (r_hs) begin
                rd_pend = 1'b0;
                r_cnt   = 2'(rand_bits(2));
            end
            if (aw_hs) begin
                aw_got = 1'b1;
                aw_cnt = 2'(rand_bits(2));
            end
            if (w_hs) begin
                w_got = 1'b1;
                w_cnt = 2'(rand_bits(2));
            end
            if (b_hs) begin
                aw_got = 1'b0;
                w_got  = 1'b0;
                b_cnt  = 2'(rand_bits(2));
            end
            arready = arvalid && ar_cnt == 0;
            if (arvalid && ar_cnt != 0) ar_cnt--;
            rvalid = rd_pend && r_cnt == 0;
            if (rd_pend && r_cnt != 0) r_cnt--;
            rdata = mem[rd_addr[9:2]];
            awready = awvalid && aw_cnt == 0;
            if (awvalid && aw_cnt != 0) aw_cnt--;
            wready = wvalid && w_cnt == 0;
            if (wvalid && w_cnt != 0) w_cnt--;
            bvalid = aw_got && w_got && b_cnt == 0;
            if (aw_got && w_got && b_cnt != 0) b_cnt--;
        end
    end

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        int cycles;
        int limit;
        rst_n   = 1'b0;
        arready = 1'b0;
        rvalid  = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        rdata   = '0;
        lfsr_q  = 16'd43098;
        build_image();
        limit  = n_words * CPI_MAX + 64;
        cycles = 0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        while (!halted && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        @(negedge clock);
        $display("checks %0d, errors %0d, cycles %0d", n_checks, n_errors, cycles);
        if (!halted) begin
            $display("timeout: the program did not reach its final loop in %0d cycles", limit);
            $display("TB FAILED");
        end else if (n_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
cpu_pkg.sv
cpu_ifu.sv
cpu_idu.sv
cpu_regfile.sv
cpu_exu.sv
cpu_lsu.sv
cpu_pcu.sv
cpu_top.sv
tb_sva.sv
tb_checker.sv
tb_top.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_top \
    -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" sim.log; then
    exit 0
fi
exit 1
